//--- dataCache.f
src/cachePkg.sv
src/cacheControl.sv
src/cacheArray.sv
src/lineFillBuffer.sv
src/lineWriteBuffer.sv
src/memArbiter.sv
src/dataCache.sv
testbench/memModel.sv
testbench/dataCacheTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f dataCache.f --top-module dataCacheTb -Mdir "$buildDir" -o simDataCache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simDataCache" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation run returned status $runStatus"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$logFile"; then
    exit 0
fi
exit 1

//--- src/cacheArray.sv
`timescale 1ns/1ps

module cacheArray (
    input  logic           Clk,
    input  logic           rst,
    input  cachePkg::addrT addr,
    input  cachePkg::wordT wdata,
    input  logic           wordWrite,
    input  logic           lineWrite,
    input  cachePkg::addrT lineAddr,    // Address of the line being filled
    input  cachePkg::lineT fillLine,
    input  logic           lineDirty,
    output cachePkg::wordT rdata,
    output logic           hit,
    output logic           victimDirty,
    output cachePkg::lineT victimLine,
    output cachePkg::addrT victimAddr
);

    cachePkg::tagT tags [2**cachePkg::indexBits];
    cachePkg::lineT lines [2**cachePkg::indexBits];
    logic [2**cachePkg::indexBits-1:0] valid;
    logic [2**cachePkg::indexBits-1:0] dirty;

    cachePkg::tagT    tag;
    cachePkg::tagT    lineTag;
    cachePkg::indexT  idx;
    cachePkg::indexT  lineIdx;
    cachePkg::offsetT off;

    assign tag = addr[31 -: cachePkg::tagBits];
    assign idx = addr[cachePkg::offsetBits + 2 +: cachePkg::indexBits];
    assign off = addr[2 +: cachePkg::offsetBits];
    assign lineTag = lineAddr[31 -: cachePkg::tagBits];
    assign lineIdx = lineAddr[cachePkg::offsetBits + 2 +: cachePkg::indexBits];

    assign hit = valid[idx] && (tags[idx] == tag);
    assign victimDirty = valid[idx] && dirty[idx];
    assign victimLine = lines[idx];
    assign victimAddr = {tags[idx], idx, {(cachePkg::offsetBits + 2){1'b0}}};
    assign rdata = victimLine[off*cachePkg::wordBits +: cachePkg::wordBits];

    // Line state bits
    always_ff @(posedge Clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (lineWrite) begin
            valid[lineIdx] <= 1'b1;
            dirty[lineIdx] <= lineDirty;  // Set when a store was merged in
        end else if (wordWrite) begin
            dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (lineWrite) begin
            lines[lineIdx] <= fillLine;
            tags[lineIdx] <= lineTag;
        end else if (wordWrite) begin
            lines[idx][off*cachePkg::wordBits +: cachePkg::wordBits] <= wdata;
        end
    end

endmodule

//--- src/cacheControl.sv
`timescale 1ns/1ps

module cacheControl (
    input  logic           Clk,
    input  logic           rst,
    input  logic           en,
    input  logic           rw,            // High for a store
    input  cachePkg::addrT addr,
    input  logic           hit,
    input  logic           victimDirty,
    input  logic           firstWord,
    input  logic           fillDone,
    input  logic           wbDone,
    output logic           stall,
    output logic           fillStart,
    output logic           wbStart,
    output logic           wordWrite,
    output logic           lineWrite,
    output logic           mergeStore,
    output logic           readFromFill
);

    cachePkg::readStateT  readState;
    cachePkg::writeStateT writeState;
    cachePkg::indexT      idx;
    cachePkg::indexT      fillIndex;     // Line owned by the fill buffer
    logic fillBusy;
    logic wbBusy;
    logic fillClear;
    logic wbClear;
    logic missStart;
    logic missPhase;
    logic sameLine;
    logic readStall;
    logic writeStall;

    assign idx = addr[cachePkg::offsetBits + 2 +: cachePkg::indexBits];
    assign sameLine = (idx == fillIndex);

    // Buffer finished now or earlier
    assign fillClear = fillDone || !fillBusy;
    assign wbClear = wbDone || !wbBusy;

    assign missPhase = (readState == cachePkg::readMissDirty) ||
                       (readState == cachePkg::readMissClean);

    assign missStart = en && !hit && (readState == cachePkg::readIdle) &&
                       (writeState == cachePkg::writeIdle);

    //////////////////////////////////////////////////
    // Stall and strobes
    //////////////////////////////////////////////////

    always_comb begin
        case (readState)
            cachePkg::readIdle:      readStall = (writeState == cachePkg::writeIdle) && !hit;
            cachePkg::readMissDirty,
            cachePkg::readMissClean: readStall = !firstWord;
            // Hits to other lines go ahead during the refill
            cachePkg::waitDirty,
            cachePkg::waitClean:     readStall = !hit || sameLine;
            default:                 readStall = 1'b1;
        endcase
    end

    // Store miss holds the CPU until the merged line is written
    assign writeStall = (writeState != cachePkg::writeIdle) &&
                        (writeState != cachePkg::mergeLine);

    assign stall = en && (readStall || writeStall);

    assign fillStart = missStart;
    assign wbStart = missStart && victimDirty;
    assign mergeStore = missStart && rw;
    assign readFromFill = missPhase && firstWord;   // Critical word bypass
    assign wordWrite = en && rw && hit && !stall;
    assign lineWrite = (readState == cachePkg::fillLine) ||
                       (writeState == cachePkg::mergeLine);

    //////////////////////////////////////////////////
    // Occupancy shared by both machines
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            fillBusy <= 1'b0;
            wbBusy <= 1'b0;
        end else begin
            if (fillStart)
                fillBusy <= 1'b1;
            else if (fillDone)
                fillBusy <= 1'b0;
            if (wbStart)
                wbBusy <= 1'b1;
            else if (wbDone)
                wbBusy <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (fillStart)
            fillIndex <= idx;
    end

    //////////////////////////////////////////////////
    // Read machine
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            readState <= cachePkg::readIdle;
        end else begin
            case (readState)
                cachePkg::readIdle: begin
                    if (missStart && !rw) begin
                        if (victimDirty)
                            readState <= cachePkg::readMissDirty;
                        else
                            readState <= cachePkg::readMissClean;
                    end
                end
                cachePkg::readMissDirty: begin
                    if (firstWord)
                        readState <= cachePkg::waitDirty;
                end
                cachePkg::readMissClean: begin
                    if (firstWord)
                        readState <= cachePkg::waitClean;
                end
                cachePkg::waitDirty: begin
                    if (fillClear && wbClear)
                        readState <= cachePkg::fillLine;
                end
                cachePkg::waitClean: begin
                    if (fillClear)
                        readState <= cachePkg::fillLine;
                end
                default: readState <= cachePkg::readIdle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Write machine
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            writeState <= cachePkg::writeIdle;
        end else begin
            case (writeState)
                cachePkg::writeIdle: begin
                    if (missStart && rw) begin
                        if (victimDirty)
                            writeState <= cachePkg::startFetchWb;
                        else
                            writeState <= cachePkg::startFetch;
                    end
                end
                cachePkg::startFetchWb: begin
                    if (fillClear && wbClear)
                        writeState <= cachePkg::mergeLine;
                end
                cachePkg::startFetch: begin
                    if (fillClear)
                        writeState <= cachePkg::mergeLine;
                end
                default: writeState <= cachePkg::writeIdle;  // Store completes here
            endcase
        end
    end

endmodule

//--- src/cachePkg.sv
package cachePkg;

    //////////////////////////////////////////////////
    // Geometry of the direct-mapped cache
    //////////////////////////////////////////////////

    localparam int wordBits   = 32;
    localparam int lineWords  = 8;  // 32 byte lines
    localparam int offsetBits = 3;  // Word within a line
    localparam int indexBits  = 7;  // 128 lines
    localparam int tagBits    = 20;

    typedef logic [wordBits-1:0]           wordT;
    typedef logic [31:0]                   addrT;
    typedef logic [tagBits-1:0]            tagT;
    typedef logic [indexBits-1:0]          indexT;
    typedef logic [offsetBits-1:0]         offsetT;
    typedef logic [lineWords*wordBits-1:0] lineT;

    // Read miss handling
    typedef enum logic [2:0] {
        readIdle,
        readMissDirty,  // Waiting for the critical word with a victim to drain
        readMissClean,
        waitDirty,      // CPU released and refill running in the background
        waitClean,
        fillLine        // Refilled line goes into the array
    } readStateT;

    // Write miss handling
    typedef enum logic [1:0] {
        writeIdle,
        startFetchWb,
        startFetch,
        mergeLine
    } writeStateT;

endpackage

//--- src/dataCache.sv
`timescale 1ns/1ps

module dataCache (
    input  logic           Clk,
    input  logic           rst,
    input  logic           en,
    input  logic           rw,
    input  cachePkg::addrT addr,
    input  cachePkg::wordT wdata,
    output cachePkg::wordT rdata,
    output logic           stall,
    output logic           memReq,
    output logic           memWe,
    output cachePkg::addrT memAddr,
    output cachePkg::wordT memWdata,
    input  cachePkg::wordT memRdata,
    input  logic           memValid
);

    logic hit, victimDirty, firstWord, fillDone, wbDone;
    logic fillStart, wbStart, wordWrite, lineWrite, mergeStore, readFromFill;
    logic lineDirty, fillReq, wbReq, fillGrant, wbGrant;
    cachePkg::wordT arrayData, firstData, wbWdata;
    cachePkg::lineT victimLine, fillLine;
    cachePkg::addrT victimAddr, fillAddr, wbAddr;

    // Critical word bypass on a read miss
    assign rdata = readFromFill ? firstData : arrayData;

    cacheControl control (
        .Clk(Clk), .rst(rst), .en(en), .rw(rw), .addr(addr),
        .hit(hit), .victimDirty(victimDirty), .firstWord(firstWord),
        .fillDone(fillDone), .wbDone(wbDone), .stall(stall),
        .fillStart(fillStart), .wbStart(wbStart), .wordWrite(wordWrite),
        .lineWrite(lineWrite), .mergeStore(mergeStore), .readFromFill(readFromFill)
    );

    cacheArray array (
        .Clk(Clk), .rst(rst), .addr(addr), .wdata(wdata),
        .wordWrite(wordWrite), .lineWrite(lineWrite), .lineAddr(fillAddr),
        .fillLine(fillLine), .lineDirty(lineDirty), .rdata(arrayData),
        .hit(hit), .victimDirty(victimDirty), .victimLine(victimLine),
        .victimAddr(victimAddr)
    );

    lineFillBuffer fillBuf (
        .Clk(Clk), .rst(rst), .fillStart(fillStart), .addr(addr), .wdata(wdata),
        .mergeStore(mergeStore), .grant(fillGrant), .memValid(memValid),
        .memRdata(memRdata), .memReq(fillReq), .memAddr(fillAddr),
        .firstWord(firstWord), .firstData(firstData), .fillDone(fillDone),
        .fillLine(fillLine), .lineDirty(lineDirty)
    );

    lineWriteBuffer wbBuf (
        .Clk(Clk), .rst(rst), .wbStart(wbStart), .victimLine(victimLine),
        .victimAddr(victimAddr), .grant(wbGrant), .memValid(memValid),
        .memReq(wbReq), .memAddr(wbAddr), .memWdata(wbWdata), .wbDone(wbDone)
    );

    memArbiter arbiter (
        .Clk(Clk), .rst(rst), .fillReq(fillReq), .fillAddr(fillAddr),
        .wbReq(wbReq), .wbAddr(wbAddr), .wbWdata(wbWdata), .memValid(memValid),
        .fillGrant(fillGrant), .wbGrant(wbGrant), .memReq(memReq),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

endmodule

//--- src/lineFillBuffer.sv
`timescale 1ns/1ps

module lineFillBuffer (
    input  logic           Clk,
    input  logic           rst,
    input  logic           fillStart,
    input  cachePkg::addrT addr,
    input  cachePkg::wordT wdata,
    input  logic           mergeStore,
    input  logic           grant,
    input  logic           memValid,
    input  cachePkg::wordT memRdata,
    output logic           memReq,
    output cachePkg::addrT memAddr,
    output logic           firstWord,
    output cachePkg::wordT firstData,
    output logic           fillDone,
    output cachePkg::lineT fillLine,
    output logic           lineDirty
);

    logic busy;
    logic wordIn;
    cachePkg::offsetT critOff;
    cachePkg::offsetT count;       // Words received so far
    cachePkg::offsetT curOff;
    cachePkg::wordT   storeData;
    logic [cachePkg::tagBits+cachePkg::indexBits-1:0] lineBase;

    assign wordIn = busy && grant && memValid;
    assign curOff = critOff + count;  // Wraps round the line
    assign memReq = busy;
    assign memAddr = {lineBase, curOff, 2'b00};

    assign firstWord = wordIn && (count == '0);
    assign firstData = memRdata;
    assign fillDone = wordIn && (count == '1);

    always_ff @(posedge Clk) begin
        if (rst) begin
            busy <= 1'b0;
            count <= '0;
            lineDirty <= 1'b0;
        end else if (fillStart) begin
            busy <= 1'b1;
            count <= '0;
            lineDirty <= mergeStore;
        end else if (wordIn) begin
            count <= count + cachePkg::offsetT'(1);
            if (count == '1)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (fillStart) begin
            lineBase <= addr[31 -: cachePkg::tagBits + cachePkg::indexBits];
            critOff <= addr[2 +: cachePkg::offsetBits];
            storeData <= wdata;
        end
        // Store word replaces the critical word on a write miss
        if (wordIn) begin
            if (lineDirty && (count == '0))
                fillLine[curOff*cachePkg::wordBits +: cachePkg::wordBits] <= storeData;
            else
                fillLine[curOff*cachePkg::wordBits +: cachePkg::wordBits] <= memRdata;
        end
    end

endmodule

//--- src/lineWriteBuffer.sv
`timescale 1ns/1ps

module lineWriteBuffer (
    input  logic           Clk,
    input  logic           rst,
    input  logic           wbStart,
    input  cachePkg::lineT victimLine,
    input  cachePkg::addrT victimAddr,
    input  logic           grant,
    input  logic           memValid,
    output logic           memReq,
    output cachePkg::addrT memAddr,
    output cachePkg::wordT memWdata,
    output logic           wbDone
);

    logic busy;
    logic wordOut;
    cachePkg::offsetT count;
    cachePkg::lineT   lineBuf;
    logic [cachePkg::tagBits+cachePkg::indexBits-1:0] lineBase;

    assign wordOut = busy && grant && memValid;
    assign memReq = busy;
    assign memAddr = {lineBase, count, 2'b00};  // Plain offset order
    assign memWdata = lineBuf[count*cachePkg::wordBits +: cachePkg::wordBits];
    assign wbDone = wordOut && (count == '1);

    always_ff @(posedge Clk) begin
        if (rst) begin
            busy <= 1'b0;
            count <= '0;
        end else if (wbStart) begin
            busy <= 1'b1;
            count <= '0;
        end else if (wordOut) begin
            count <= count + cachePkg::offsetT'(1);
            if (count == '1)
                busy <= 1'b0;
        end
    end

    // Whole victim captured in one cycle
    always_ff @(posedge Clk) begin
        if (wbStart) begin
            lineBuf <= victimLine;
            lineBase <= victimAddr[31 -: cachePkg::tagBits + cachePkg::indexBits];
        end
    end

endmodule

//--- src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic           Clk,
    input  logic           rst,
    input  logic           fillReq,
    input  cachePkg::addrT fillAddr,
    input  logic           wbReq,
    input  cachePkg::addrT wbAddr,
    input  cachePkg::wordT wbWdata,
    input  logic           memValid,
    output logic           fillGrant,
    output logic           wbGrant,
    output logic           memReq,
    output logic           memWe,
    output cachePkg::addrT memAddr,
    output cachePkg::wordT memWdata
);

    logic locked;    // Word transaction in flight
    logic lockFill;

    always_comb begin
        if (locked) begin
            fillGrant = lockFill;
            wbGrant = !lockFill;
        end else begin
            fillGrant = fillReq;             // Fill side wins
            wbGrant = !fillReq && wbReq;
        end
    end

    assign memReq = (fillGrant && fillReq) || (wbGrant && wbReq);
    assign memWe = wbGrant;
    assign memAddr = wbGrant ? wbAddr : fillAddr;
    assign memWdata = wbWdata;

    // Grant held from request until memValid
    always_ff @(posedge Clk) begin
        if (rst) begin
            locked <= 1'b0;
            lockFill <= 1'b0;
        end else if (locked) begin
            if (memValid)
                locked <= 1'b0;
        end else if (memReq) begin
            locked <= 1'b1;
            lockFill <= fillGrant;
        end
    end

endmodule

//--- testbench/dataCacheTb.sv
`timescale 1ns/1ps

module dataCacheTb;

    localparam int period = 4;
    localparam int fixedRows = 10;
    localparam int randomRows = 40;
    localparam int numRows = fixedRows + randomRows;

    logic           Clk;
    logic           rst;
    logic           en;
    logic           rw;
    cachePkg::addrT addr;
    cachePkg::wordT wdata;
    cachePkg::wordT rdata;
    logic           stall;
    logic           memReq;
    logic           memWe;
    cachePkg::addrT memAddr;
    cachePkg::wordT memWdata;
    cachePkg::wordT memRdata;
    logic           memValid;

    // Operation table
    int             rowTest  [numRows];
    logic           rowRw    [numRows];
    cachePkg::addrT rowAddr  [numRows];
    cachePkg::wordT rowData  [numRows];
    logic           rowCheck [numRows];
    logic           rowQuiet [numRows];  // Bus idle first, then a zero-wait hit
    int             rowCount;

    cachePkg::wordT shadow [cachePkg::addrT];  // Written words by byte address
    int errors [1:6];
    int checks;

    dataCache UUT (
        .Clk(Clk), .rst(rst), .en(en), .rw(rw), .addr(addr), .wdata(wdata),
        .rdata(rdata), .stall(stall), .memReq(memReq), .memWe(memWe),
        .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata), .memValid(memValid)
    );

    memModel memory (
        .Clk(Clk), .rst(rst), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWdata(memWdata), .memRdata(memRdata), .memValid(memValid)
    );

    initial begin
        Clk = 1'b0;
        forever #(period / 2) Clk = ~Clk;
    end

    // Generous bound per access
    initial begin
        #(numRows * 200 * period);
        $display("watchdog expired: access never completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic string testName(input int t);
        case (t)
            1: return "after reset";
            2: return "clean read miss then hit";
            3: return "write hit then read back";
            4: return "dirty eviction";
            5: return "write miss allocate";
            default: return "random tail";
        endcase
    endfunction

    function automatic cachePkg::wordT expectedWord(input cachePkg::addrT a);
        if (shadow.exists(a))
            return shadow[a];
        return (a >> 2) ^ 32'hA5A5_0000;  // Memory pattern by word address
    endfunction

    task automatic addRow(input int test, input logic isWrite, input cachePkg::addrT a,
                          input cachePkg::wordT d, input logic check, input logic quiet);
        rowTest[rowCount] = test;
        rowRw[rowCount] = isWrite;
        rowAddr[rowCount] = a;
        rowData[rowCount] = d;
        rowCheck[rowCount] = check;
        rowQuiet[rowCount] = quiet;
        rowCount++;
    endtask

    //////////////////////////////////////////////////
    // Table of accesses
    //////////////////////////////////////////////////

    task automatic buildTable();
        int tag;
        int idx;
        int off;
        logic isWrite;
        cachePkg::addrT a;
        rowCount = 0;
        addRow(2, 1'b0, 32'h0000_1040, '0, 1'b1, 1'b0);
        addRow(2, 1'b0, 32'h0000_1054, '0, 1'b1, 1'b1);  // After the refill
        addRow(3, 1'b1, 32'h0000_1048, 32'h1234_5678, 1'b0, 1'b0);
        addRow(3, 1'b0, 32'h0000_1048, '0, 1'b1, 1'b0);
        // Same index, other tag, evicts the dirty line
        addRow(4, 1'b0, 32'h0000_2040, '0, 1'b1, 1'b0);
        addRow(4, 1'b0, 32'h0000_1048, '0, 1'b1, 1'b0);
        addRow(4, 1'b0, 32'h0000_1040, '0, 1'b1, 1'b0);
        addRow(5, 1'b1, 32'h0000_310C, 32'hCAFE_0001, 1'b0, 1'b0);
        addRow(5, 1'b0, 32'h0000_310C, '0, 1'b1, 1'b0);
        addRow(5, 1'b0, 32'h0000_3110, '0, 1'b1, 1'b0);
        for (int i = 0; i < randomRows; i++) begin
            tag = 1 + int'($urandom_range(3, 0));
            idx = ($urandom_range(1, 0) == 1) ? 9 : 2;
            off = int'($urandom_range(7, 0));
            isWrite = ($urandom_range(1, 0) == 1);
            a = (tag << 12) | (idx << 5) | (off << 2);
            addRow(6, isWrite, a, $urandom(), !isWrite, 1'b0);
        end
    endtask

    // Lets the refill drain so the next access is a plain hit
    task automatic waitBusIdle();
        en = 1'b0;
        #1;
        while (memReq) begin
            @(negedge Clk);
            #1;
        end
        repeat (2) @(negedge Clk);
    endtask

    // Called at a falling edge, returns at the one after the completing edge
    task automatic runAccess(input int i, output int waits, output cachePkg::wordT got);
        en = 1'b1;
        rw = rowRw[i];
        addr = rowAddr[i];
        wdata = rowData[i];
        waits = 0;
        #1;
        while (stall) begin
            @(negedge Clk);
            #1;
            waits++;
        end
        got = rdata;
        @(negedge Clk);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int waits;
        int t;
        int total;
        cachePkg::wordT got;
        cachePkg::wordT exp;
        void'($urandom(81));
        rst = 1'b1;
        en = 1'b0;
        rw = 1'b0;
        addr = '0;
        wdata = '0;
        checks = 0;
        for (int n = 1; n <= 6; n++)
            errors[n] = 0;
        buildTable();
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        #1;
        checks += 2;
        assert (stall == 1'b0) else begin
            $display("** Error at %0d ns: stall expected 0, got %b", $time, stall);
            errors[1]++;
        end
        assert (memReq == 1'b0) else begin
            $display("** Error at %0d ns: memReq expected 0, got %b", $time, memReq);
            errors[1]++;
        end
        $display("Test 1 %s: %0d errors", testName(1), errors[1]);
        @(negedge Clk);

        for (int i = 0; i < rowCount; i++) begin
            t = rowTest[i];
            if (rowQuiet[i])
                waitBusIdle();
            runAccess(i, waits, got);
            if (rowQuiet[i]) begin
                checks++;
                assert (waits == 0) else begin
                    $display("** Error at %0d ns: stall expected 0, got 1 for %0d cycles",
                             $time, waits);
                    errors[t]++;
                end
            end
            if (rowCheck[i]) begin
                exp = expectedWord(rowAddr[i]);
                checks++;
                assert (got == exp) else begin
                    $display("** Error at %0d ns: rdata at %h expected %h, got %h",
                             $time, rowAddr[i], exp, got);
                    errors[t]++;
                end
            end
            if (rowRw[i])
                shadow[rowAddr[i]] = rowData[i];
            if ((i + 1 == rowCount) || (rowTest[i + 1] != t))
                $display("Test %0d %s: %0d errors", t, testName(t), errors[t]);
        end

        total = 0;
        for (int n = 1; n <= 6; n++)
            total += errors[n];
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- testbench/memModel.sv
`timescale 1ns/1ps

module memModel (
    input  logic           Clk,
    input  logic           rst,
    input  logic           memReq,
    input  logic           memWe,
    input  cachePkg::addrT memAddr,
    input  cachePkg::wordT memWdata,
    output cachePkg::wordT memRdata,
    output logic           memValid
);

    cachePkg::wordT mem [cachePkg::addrT];  // Only words written so far
    cachePkg::addrT wordAddr;
    logic pending;
    int   waitLeft;

    assign wordAddr = {2'b00, memAddr[31:2]};

    // Untouched words read back as a pattern of their address
    function automatic cachePkg::wordT readWord(input cachePkg::addrT a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    //////////////////////////////////////////////////
    // One word transaction at a time
    //////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (rst) begin
            pending <= 1'b0;
            memValid <= 1'b0;
            memRdata <= '0;
            waitLeft <= 0;
        end else if (memValid) begin
            memValid <= 1'b0;  // One-cycle pulse
        end else if (pending) begin
            if (waitLeft == 0) begin
                pending <= 1'b0;
                memValid <= 1'b1;
                if (memWe)
                    mem[wordAddr] = memWdata;
                else
                    memRdata <= readWord(wordAddr);
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end else if (memReq) begin
            pending <= 1'b1;
            waitLeft <= int'($urandom_range(5, 0));  // 1 to 6 cycles
        end
    end

endmodule
